/* accel_controller.f */
accel_pkg.sv
mem_init_writer.sv
stride_sequencer.sv
phase_controller.sv
accel_controller.sv
accel_controller_assertions.sv
tb_accel_controller.sv

/* Makefile */
VERILATOR ?= verilator
TB_TOP    ?= tb_accel_controller
RTL_TOP   ?= accel_controller
FILELIST  ?= accel_controller.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TB_TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	grep -F -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_accel_controller.sv */
`timescale 1ns/1ps

module tb_accel_controller;

    localparam int num_tests      = 5;
    localparam int test_time_ns   = 4000;
    localparam int p_start_sa     = 0;
    localparam int p_start_custom = 1;
    localparam int p_serial_done  = 2;
    localparam int p_preload_done = 3;
    localparam int p_feature_done = 4;
    localparam int p_custom_done  = 5;
    localparam int p_display_done = 6;

    logic                  clk;
    logic                  rst;
    logic [6:0]            pulse_in;    // Start and done strobes.
    logic                  rst_computation_module;
    logic                  rst_display_module;
    accel_pkg::data_t      data;
    accel_pkg::addr_t      addr_0;
    logic                  we_0;
    logic                  mem_sel;
    accel_pkg::addr_t      serial_mode_feature_baseaddr;
    accel_pkg::addr_t      systolic_mode_feature_baseaddr;
    logic                  serial_mode_en;
    logic                  weight_preloader_en;
    logic                  feature_loader_en;
    logic                  custom_mode_en;
    logic                  systolic_mode;
    logic [1:0]            c_reg_sel;
    accel_pkg::comp_mode_t computation_mode_sel;
    logic                  display_mode_en;
    logic                  sel_display;
    logic [31:0]           lcg_state;
    string                 cur_test;
    int                    errors;
    int                    test_errors;
    int                    tests_failed;

    accel_controller #(
        .serial_drain_cycles   (2),
        .systolic_drain_cycles (4)
    ) DUT (
        .start_sa              (pulse_in[p_start_sa]),
        .start_custom          (pulse_in[p_start_custom]),
        .serial_mode_done      (pulse_in[p_serial_done]),
        .weight_preloader_done (pulse_in[p_preload_done]),
        .feature_loader_done   (pulse_in[p_feature_done]),
        .custom_mode_done      (pulse_in[p_custom_done]),
        .display_done          (pulse_in[p_display_done]),
        .*
    );

    always #2 clk = ~clk;

    // Response delay of a model compute unit.
    function automatic int rand_delay();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return 1 + int'((lcg_state >> 16) % 32'd6);     // 1 to 6 cycles.
    endfunction

    function automatic int expected_data(int k);
        if (k < 9) begin
            return k / 3 + 1;                           // Weight column index plus one.
        end
        return (k - 9) % 4 + 1;
    endfunction

    // Window origin inside the 4x4 feature block at address 9.
    function automatic int expected_base(int s);
        return 9 + (s / 2) * 4 + (s % 2);
    endfunction

    task automatic check_val(string sig, int expected, logic [31:0] actual);
        if (actual !== 32'(expected)) begin
            $display("Mismatch in %s, %s: expected %0d, actual %0d",
                     cur_test, sig, expected, actual);
            test_errors++;
        end
    endtask

    task pulse(input int idx);
        @(posedge clk);
        pulse_in[idx] <= 1'b1;
        @(posedge clk);
        pulse_in[idx] <= 1'b0;
    endtask

    task automatic end_test();
        if (test_errors == 0) begin
            $display("%s: passed", cur_test);
        end else begin
            $display("%s: failed with %0d errors", cur_test, test_errors);
            tests_failed++;
        end
        errors += test_errors;
        test_errors = 0;
    endtask

    task automatic test_reset_idle();
        cur_test = "reset_idle";
        repeat (8) begin
            @(negedge clk);
            check_val("we_0", 0, 32'(we_0));
            check_val("enables", 0, 32'({serial_mode_en, feature_loader_en,
                                          weight_preloader_en, custom_mode_en}));
            check_val("mem_sel", 0, 32'(mem_sel));
            check_val("display_mode_en", 0, 32'(display_mode_en));
            check_val("module resets", 3, 32'({rst_computation_module, rst_display_module}));
        end
        end_test();
    endtask

    task automatic test_table_init();
        cur_test = "table_init";
        pulse(p_start_sa);
        for (int k = 0; k < 25; k++) begin
            @(negedge clk);
            check_val("we_0", 1, 32'(we_0));
            check_val("addr_0", k, 32'(addr_0));
            check_val("data", expected_data(k), 32'(data));
            check_val("rst_computation_module", (k == 24) ? 0 : 1,
                      32'(rst_computation_module));
        end
        @(negedge clk);
        check_val("we_0 after table", 0, 32'(we_0));
        check_val("data after table", 0, 32'(data));
        end_test();
    endtask

    // Four strides, each ended by a delayed done from the model unit.
    task automatic run_strides(logic systolic);
        logic extra;
        extra = 1'b0;
        for (int s = 0; s < 4; s++) begin
            @(negedge clk);
            while (!(systolic ? feature_loader_en : serial_mode_en)) @(negedge clk);
            repeat (rand_delay()) begin
                check_val("stride enable", 1,
                          32'(systolic ? feature_loader_en : serial_mode_en));
                check_val("base address", expected_base(s),
                          32'(systolic ? systolic_mode_feature_baseaddr
                                       : serial_mode_feature_baseaddr));
                check_val("systolic_mode", systolic ? 1 : 0, 32'(systolic_mode));
                check_val("computation_mode_sel",
                          systolic ? 32'(accel_pkg::mode_systolic) : 32'(accel_pkg::mode_serial),
                          32'(computation_mode_sel));
                if (systolic) begin
                    check_val("c_reg_sel", s, 32'(c_reg_sel));
                end
                @(negedge clk);
            end
            pulse(systolic ? p_feature_done : p_serial_done);
        end
        @(negedge clk);
        while (!(systolic ? display_mode_en : weight_preloader_en)) begin
            extra = extra | (systolic ? feature_loader_en : serial_mode_en);
            @(negedge clk);
        end
        if (extra) begin
            $display("Error in %s: a stride started after the fourth done", cur_test);
            test_errors++;
        end
    endtask

    task automatic test_serial_strides();
        cur_test = "serial_strides";
        run_strides(1'b0);
        end_test();
    endtask

    task automatic test_systolic_strides();
        cur_test = "systolic_strides";
        repeat (rand_delay()) begin
            check_val("weight_preloader_en", 1, 32'(weight_preloader_en));
            @(negedge clk);
        end
        pulse(p_preload_done);
        run_strides(1'b1);
        end_test();
    endtask

    task automatic test_display_custom();
        cur_test = "display_custom";
        check_val("sel_display", 0, 32'(sel_display));
        check_val("rst_display_module", 0, 32'(rst_display_module));
        repeat (rand_delay()) @(negedge clk);
        pulse(p_display_done);
        repeat (rand_delay()) begin
            @(negedge clk);
            check_val("custom_mode_en before start", 0, 32'(custom_mode_en));
        end
        pulse(p_start_custom);
        @(negedge clk);
        repeat (rand_delay()) begin
            check_val("custom_mode_en", 1, 32'(custom_mode_en));
            check_val("computation_mode_sel", 32'(accel_pkg::mode_custom),
                      32'(computation_mode_sel));
            @(negedge clk);
        end
        pulse(p_custom_done);
        @(negedge clk);
        while (!display_mode_en) @(negedge clk);
        check_val("sel_display", 1, 32'(sel_display));
        check_val("custom_mode_en after done", 0, 32'(custom_mode_en));
        pulse(p_display_done);
        pulse(p_start_sa);                              // Lands in idle after finish.
        @(negedge clk);
        check_val("we_0 on restart", 1, 32'(we_0));
        check_val("addr_0 on restart", 0, 32'(addr_0));
        check_val("data on restart", expected_data(0), 32'(data));
        end_test();
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b0;
        pulse_in     = '0;
        lcg_state    = 32'hf69baa18;
        errors       = 0;
        test_errors  = 0;
        tests_failed = 0;
        repeat (3) @(posedge clk);
        rst <= 1'b1;
        test_reset_idle();
        test_table_init();
        test_serial_strides();
        test_systolic_strides();
        test_display_custom();
        $display("Tests: %0d, failed: %0d, errors: %0d, assertion failures: %0d",
                 num_tests, tests_failed, errors, DUT.u_assert.fail_cnt);
        if (errors == 0 && DUT.u_assert.fail_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        #(num_tests * test_time_ns);
        $display("Timeout: the run did not finish within %0d ns", num_tests * test_time_ns);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

/* accel_controller_assertions.sv */
`timescale 1ns/1ps

module accel_controller_assertions (
    input logic clk,
    input logic rst,
    input logic we_0,
    input logic serial_mode_en,
    input logic feature_loader_en,
    input logic display_mode_en
);

    int fail_cnt = 0;

    // Table writes end before the first stride.
    we_vs_stride: assert property (@(posedge clk) disable iff (!rst)
        !(we_0 && (serial_mode_en || feature_loader_en)))
        else begin
            $error("we_0 high together with a stride enable");
            fail_cnt++;
        end

    enables_exclusive: assert property (@(posedge clk) disable iff (!rst)
        !(serial_mode_en && feature_loader_en))
        else begin
            $error("serial_mode_en and feature_loader_en both high");
            fail_cnt++;
        end

    display_pulse: assert property (@(posedge clk) disable iff (!rst)
        display_mode_en |=> !display_mode_en)
        else begin
            $error("display_mode_en held longer than one cycle");
            fail_cnt++;
        end

endmodule

bind accel_controller accel_controller_assertions u_assert (
    .clk               (clk),
    .rst               (rst),
    .we_0              (we_0),
    .serial_mode_en    (serial_mode_en),
    .feature_loader_en (feature_loader_en),
    .display_mode_en   (display_mode_en)
);

/* accel_controller.sv */
`timescale 1ns/1ps

module accel_controller #(
    parameter int serial_drain_cycles   = 2,
    parameter int systolic_drain_cycles = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start_sa,
    input  logic                  start_custom,
    input  logic                  serial_mode_done,
    input  logic                  weight_preloader_done,
    input  logic                  feature_loader_done,
    input  logic                  custom_mode_done,
    input  logic                  display_done,
    output logic                  rst_computation_module,
    output logic                  rst_display_module,
    output accel_pkg::data_t      data,
    output accel_pkg::addr_t      addr_0,
    output logic                  we_0,
    output logic                  mem_sel,
    output accel_pkg::addr_t      serial_mode_feature_baseaddr,
    output accel_pkg::addr_t      systolic_mode_feature_baseaddr,
    output logic                  serial_mode_en,
    output logic                  weight_preloader_en,
    output logic                  feature_loader_en,
    output logic                  custom_mode_en,
    output logic                  systolic_mode,
    output logic [1:0]            c_reg_sel,
    output accel_pkg::comp_mode_t computation_mode_sel,
    output logic                  display_mode_en,
    output logic                  sel_display
);

    logic       init_start;
    logic       init_done;
    logic       serial_start;
    logic       serial_done;
    logic [1:0] serial_idx;
    logic       systolic_start;
    logic       systolic_done;
    logic [1:0] systolic_idx;

    mem_init_writer u_init_writer (
        .clk       (clk),
        .rst       (rst),
        .start     (init_start),
        .addr_0    (addr_0),
        .data      (data),
        .we_0      (we_0),
        .init_done (init_done)
    );

    stride_sequencer #(
        .drain_cycles (serial_drain_cycles)
    ) serial_seq (
        .clk        (clk),
        .rst        (rst),
        .start      (serial_start),
        .unit_done  (serial_mode_done),
        .stride_en  (serial_mode_en),
        .stride_idx (serial_idx),
        .seq_done   (serial_done)
    );

    stride_sequencer #(
        .drain_cycles (systolic_drain_cycles)
    ) systolic_seq (
        .clk        (clk),
        .rst        (rst),
        .start      (systolic_start),
        .unit_done  (feature_loader_done),
        .stride_en  (feature_loader_en),
        .stride_idx (systolic_idx),
        .seq_done   (systolic_done)
    );

    phase_controller u_phase_ctrl (
        .clk                            (clk),
        .rst                            (rst),
        .start_sa                       (start_sa),
        .start_custom                   (start_custom),
        .init_done                      (init_done),
        .serial_done                    (serial_done),
        .preload_done                   (weight_preloader_done),
        .systolic_done                  (systolic_done),
        .custom_mode_done               (custom_mode_done),
        .display_done                   (display_done),
        .serial_idx                     (serial_idx),
        .systolic_idx                   (systolic_idx),
        .init_start                     (init_start),
        .serial_start                   (serial_start),
        .systolic_start                 (systolic_start),
        .rst_computation_module         (rst_computation_module),
        .rst_display_module             (rst_display_module),
        .mem_sel                        (mem_sel),
        .weight_preloader_en            (weight_preloader_en),
        .custom_mode_en                 (custom_mode_en),
        .systolic_mode                  (systolic_mode),
        .computation_mode_sel           (computation_mode_sel),
        .serial_mode_feature_baseaddr   (serial_mode_feature_baseaddr),
        .systolic_mode_feature_baseaddr (systolic_mode_feature_baseaddr),
        .c_reg_sel                      (c_reg_sel),
        .display_mode_en                (display_mode_en),
        .sel_display                    (sel_display)
    );

endmodule

/* phase_controller.sv */
`timescale 1ns/1ps

module phase_controller (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start_sa,
    input  logic                  start_custom,
    input  logic                  init_done,
    input  logic                  serial_done,
    input  logic                  preload_done,
    input  logic                  systolic_done,
    input  logic                  custom_mode_done,
    input  logic                  display_done,
    input  logic [1:0]            serial_idx,
    input  logic [1:0]            systolic_idx,
    output logic                  init_start,
    output logic                  serial_start,
    output logic                  systolic_start,
    output logic                  rst_computation_module,
    output logic                  rst_display_module,
    output logic                  mem_sel,
    output logic                  weight_preloader_en,
    output logic                  custom_mode_en,
    output logic                  systolic_mode,
    output accel_pkg::comp_mode_t computation_mode_sel,
    output accel_pkg::addr_t      serial_mode_feature_baseaddr,
    output accel_pkg::addr_t      systolic_mode_feature_baseaddr,
    output logic [1:0]            c_reg_sel,
    output logic                  display_mode_en,
    output logic                  sel_display
);

    localparam logic [3:0] st_idle         = 4'd0;
    localparam logic [3:0] st_init         = 4'd1;
    localparam logic [3:0] st_serial       = 4'd2;
    localparam logic [3:0] st_preload      = 4'd3;
    localparam logic [3:0] st_systolic     = 4'd4;
    localparam logic [3:0] st_display      = 4'd5;
    localparam logic [3:0] st_wait_custom  = 4'd6;
    localparam logic [3:0] st_custom       = 4'd7;
    localparam logic [3:0] st_display_last = 4'd8;
    localparam logic [3:0] st_finish       = 4'd9;

    logic [3:0] state;
    logic [3:0] next_state;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state           <= st_idle;
            display_mode_en <= 1'b0;
        end else begin
            state <= next_state;
            // High in the first cycle of either display phase.
            display_mode_en <= (next_state == st_display && state != st_display) ||
                               (next_state == st_display_last && state != st_display_last);
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            st_idle:         if (start_sa) next_state = st_init;
            st_init:         if (init_done) next_state = st_serial;
            st_serial:       if (serial_done) next_state = st_preload;
            st_preload:      if (preload_done) next_state = st_systolic;
            st_systolic:     if (systolic_done) next_state = st_display;
            st_display:      if (display_done) next_state = st_wait_custom;
            st_wait_custom:  if (start_custom) next_state = st_custom;
            st_custom:       if (custom_mode_done) next_state = st_display_last;
            st_display_last: if (display_done) next_state = st_finish;
            st_finish:       next_state = st_idle;
            default:         next_state = st_idle;
        endcase
    end

    assign init_start     = (state == st_idle) && start_sa;
    assign serial_start   = (state == st_init) && init_done;
    assign systolic_start = (state == st_preload) && preload_done;

    always_comb begin
        rst_computation_module         = 1'b1;
        rst_display_module             = 1'b1;
        mem_sel                        = 1'b0;
        weight_preloader_en            = 1'b0;
        custom_mode_en                 = 1'b0;
        systolic_mode                  = 1'b0;
        computation_mode_sel           = accel_pkg::mode_serial;
        serial_mode_feature_baseaddr   = '0;
        systolic_mode_feature_baseaddr = '0;
        c_reg_sel                      = 2'd0;
        sel_display                    = 1'b0;
        case (state)
            st_init: begin
                rst_computation_module = !init_done;    // Assert on the last write.
            end
            st_serial: begin
                rst_computation_module       = 1'b0;
                mem_sel                      = 1'b1;
                serial_mode_feature_baseaddr = accel_pkg::stride_base[serial_idx];
            end
            st_preload: begin
                rst_computation_module = 1'b0;
                mem_sel                = 1'b1;
                computation_mode_sel   = accel_pkg::mode_systolic;
                weight_preloader_en    = 1'b1;
            end
            st_systolic: begin
                rst_computation_module         = 1'b0;
                mem_sel                        = 1'b1;
                computation_mode_sel           = accel_pkg::mode_systolic;
                systolic_mode                  = 1'b1;
                systolic_mode_feature_baseaddr = accel_pkg::stride_base[systolic_idx];
                c_reg_sel                      = systolic_idx;  // One result reg per stride.
            end
            st_display: begin
                rst_display_module = 1'b0;
            end
            st_custom: begin
                rst_computation_module = 1'b0;
                mem_sel                = 1'b1;
                computation_mode_sel   = accel_pkg::mode_custom;
                custom_mode_en         = 1'b1;
            end
            st_display_last: begin
                rst_display_module = 1'b0;
                sel_display        = 1'b1;
            end
            default: begin
            end
        endcase
    end

endmodule

/* stride_sequencer.sv */
`timescale 1ns/1ps

module stride_sequencer #(
    parameter int drain_cycles = 2
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  logic       unit_done,
    output logic       stride_en,
    output logic [1:0] stride_idx,
    output logic       seq_done
);

    localparam int cnt_w = $clog2(drain_cycles + 1);

    logic             draining;
    logic [cnt_w-1:0] drain_cnt;
    logic             last_stride;

    assign last_stride = (stride_idx == 2'(accel_pkg::stride_count - 1));

    always_ff @(posedge clk) begin
        if (!rst) begin
            stride_en  <= 1'b0;
            stride_idx <= 2'd0;
            draining   <= 1'b0;
            drain_cnt  <= '0;
            seq_done   <= 1'b0;
        end else begin
            seq_done <= 1'b0;
            if (start && !stride_en && !draining) begin
                stride_en  <= 1'b1;
                stride_idx <= 2'd0;
            end else if (stride_en && unit_done) begin
                if (last_stride) begin
                    stride_en <= 1'b0;
                    draining  <= 1'b1;
                    drain_cnt <= cnt_w'(drain_cycles);  // Let the pipeline empty.
                end else begin
                    stride_idx <= stride_idx + 2'd1;
                end
            end else if (draining) begin
                drain_cnt <= drain_cnt - cnt_w'(1);
                if (drain_cnt == cnt_w'(1)) begin
                    draining <= 1'b0;
                    seq_done <= 1'b1;                   // One cycle after the drain.
                end
            end
        end
    end

endmodule

/* mem_init_writer.sv */
`timescale 1ns/1ps

module mem_init_writer (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    output accel_pkg::addr_t addr_0,
    output accel_pkg::data_t data,
    output logic             we_0,
    output logic             init_done
);

    logic [4:0] wr_cnt;
    logic       busy;
    logic       last_wr;

    assign last_wr = busy && (wr_cnt == 5'(accel_pkg::init_len - 1));

    always_ff @(posedge clk) begin
        if (!rst) begin
            busy   <= 1'b0;
            wr_cnt <= '0;
        end else if (start && !busy) begin
            busy   <= 1'b1;
            wr_cnt <= '0;
        end else if (busy) begin
            if (last_wr) begin
                busy   <= 1'b0;
                wr_cnt <= '0;
            end else begin
                wr_cnt <= wr_cnt + 5'd1;
            end
        end
    end

    always_comb begin
        addr_0 = '0;
        data   = '0;                                    // Zero outside the table.
        we_0   = 1'b0;
        if (busy) begin
            addr_0 = accel_pkg::addr_t'(wr_cnt);         // Entry k lands at address k.
            data   = accel_pkg::init_data[wr_cnt];
            we_0   = 1'b1;
        end
    end

    assign init_done = last_wr;

endmodule

/* accel_pkg.sv */
package accel_pkg;

    localparam int data_w = 8;
    localparam int addr_w = 6;

    typedef logic [data_w-1:0] data_t;
    typedef logic [addr_w-1:0] addr_t;

    typedef enum logic [1:0] {
        mode_serial   = 2'b00,
        mode_systolic = 2'b01,
        mode_custom   = 2'b10
    } comp_mode_t;

    localparam int init_len     = 25;
    localparam int stride_count = 4;

    // 3x3 weights by column, then 4x4 features by row.
    localparam data_t init_data [init_len] = '{
        8'd1, 8'd1, 8'd1,
        8'd2, 8'd2, 8'd2,
        8'd3, 8'd3, 8'd3,
        8'd1, 8'd2, 8'd3, 8'd4,
        8'd1, 8'd2, 8'd3, 8'd4,
        8'd1, 8'd2, 8'd3, 8'd4,
        8'd1, 8'd2, 8'd3, 8'd4
    };

    // Top-left feature of each 3x3 window.
    localparam addr_t stride_base [stride_count] = '{
        6'd9,
        6'd10,
        6'd13,
        6'd14
    };

endpackage
